// ==== design/btbPkg.sv ====
// ======================================================================
// Approximate branch target buffer package.
// Widths, entry layout and PC slicing helpers shared by the BTB blocks.
// ======================================================================

`default_nettype none

package btbPkg;

    // Fetch address width and spacing of consecutive fetch slots.
    localparam int PC_WIDTH = 32;
    localparam int INSN_BYTES = 4;
    localparam int INSN_OFFSET = 2;

    // Entry field widths.
    localparam int BTB_INDEX_WIDTH = 6;
    localparam int BTB_TAG_WIDTH = 10;
    localparam int BTB_ADDR_WIDTH = 14;
    localparam int QUEUE_PTR_WIDTH = 2;

    // Bit positions inside a PC.
    localparam int TAG_LSB = INSN_OFFSET + BTB_INDEX_WIDTH;
    localparam int ADDR_TOP = INSN_OFFSET + BTB_ADDR_WIDTH;

    typedef logic [PC_WIDTH-1:0] pcT;
    typedef logic [BTB_INDEX_WIDTH-1:0] btbIndexT;
    typedef logic [BTB_TAG_WIDTH-1:0] btbTagT;
    typedef logic [BTB_ADDR_WIDTH-1:0] btbAddrT;
    typedef logic [QUEUE_PTR_WIDTH-1:0] qPtrT;

    // One stored entry, 26 bits.
    typedef struct packed {
        logic valid;
        logic isCondBr;
        btbTagT tag;
        btbAddrT addr;
    } btbEntryT;

    function automatic btbIndexT toBtbIndex(pcT pc);
        return pc[INSN_OFFSET +: BTB_INDEX_WIDTH];
    endfunction

    function automatic btbTagT toBtbTag(pcT pc);
        return pc[TAG_LSB +: BTB_TAG_WIDTH];
    endfunction

    // Low target bits kept in the entry, above the instruction offset.
    function automatic btbAddrT toBtbAddr(pcT target);
        return target[INSN_OFFSET +: BTB_ADDR_WIDTH];
    endfunction

    // Upper bits come from the slot address itself.
    function automatic pcT toTarget(pcT slotPc, btbAddrT addr);
        return {slotPc[PC_WIDTH-1:ADDR_TOP], addr, {INSN_OFFSET{1'b0}}};
    endfunction

endpackage

`default_nettype wire

// ==== design/btbEntryRam.sv ====
// ======================================================================
// BTB entry array.
// Register-based storage with several write ports and registered reads.
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module btbEntryRam import btbPkg::*; #(
    parameter int ENTRY_NUM = 64,
    parameter int READ_NUM = 2,
    parameter int WRITE_NUM = 2
) (
    input wire logic clk,
    input wire logic [WRITE_NUM-1:0] we,
    input wire btbIndexT [WRITE_NUM-1:0] wa,
    input wire btbEntryT [WRITE_NUM-1:0] wv,
    input wire btbIndexT [READ_NUM-1:0] ra,
    output btbEntryT [READ_NUM-1:0] rv
);

    btbEntryT entryArray [ENTRY_NUM];

    // Later ports are applied last, so the highest port wins a clash.
    always_ff @(posedge clk) begin
        for (int w = 0; w < WRITE_NUM; w++) begin
            if (we[w]) begin
                entryArray[wa[w]] <= wv[w];
            end
        end
    end

    // One cycle read latency; a same-edge write is seen next time.
    always_ff @(posedge clk) begin
        for (int r = 0; r < READ_NUM; r++) begin
            rv[r] <= entryArray[ra[r]];
        end
    end

    // The arbiter upstream should never aim two ports at one entry.
    for (genvar i = 0; i < WRITE_NUM; i++) begin : gWrA
        for (genvar j = i + 1; j < WRITE_NUM; j++) begin : gWrB
            assert property (@(posedge clk) !(we[i] && we[j] && (wa[i] == wa[j])))
                else $error("btbEntryRam: ports %0d and %0d write index %0h",
                            i, j, wa[i]);
        end
    end

endmodule

`default_nettype wire

// ==== design/updateQueuePtr.sv ====
// ======================================================================
// Update queue pointers.
// Wrapping head/tail pointers and occupancy for a small circular queue.
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module updateQueuePtr import btbPkg::*; #(
    parameter int QUEUE_SIZE = 4
) (
    input wire logic clk,
    input wire logic rstN,
    input wire logic push,
    input wire logic pop,
    output logic full,
    output logic empty,
    output qPtrT headPtr,
    output qPtrT tailPtr
);

    localparam int CNT_WIDTH = $clog2(QUEUE_SIZE + 1);

    logic [CNT_WIDTH-1:0] count;
    logic pushEn;
    logic popEn;

    assign full = (count == CNT_WIDTH'(QUEUE_SIZE));
    assign empty = (count == '0);

    // A push into a full queue is dropped.
    assign pushEn = push && !full;
    assign popEn = pop && !empty;

    function automatic qPtrT nextPtr(qPtrT ptr);
        return (ptr == qPtrT'(QUEUE_SIZE - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Head is the write side, tail the read side.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (pushEn) begin
                headPtr <= nextPtr(headPtr);
            end
            if (popEn) begin
                tailPtr <= nextPtr(tailPtr);
            end
            count <= count + CNT_WIDTH'(pushEn) - CNT_WIDTH'(popEn);
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) pop |-> !empty)
        else $error("updateQueuePtr: pop while empty");

    // Overflow loses a branch update.
    assert property (@(posedge clk) disable iff (!rstN) push |-> !full)
        else $warning("updateQueuePtr: push while full, update dropped");

endmodule

`default_nettype wire

// ==== design/branchTargetBuffer.sv ====
// ======================================================================
// Approximate branch target buffer.
// Per-slot lookup with one cycle latency, update arbitration with an
// overflow queue, and an entry clear sequence after reset.
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module branchTargetBuffer import btbPkg::*; #(
    parameter int FETCH_WIDTH = 2,
    parameter int ISSUE_WIDTH = 2,
    parameter int ENTRY_NUM = 64,
    parameter int QUEUE_SIZE = 4
) (
    input wire logic clk,
    input wire logic rstN,
    input wire pcT predNextPc,
    input wire logic [ISSUE_WIDTH-1:0] brValid,
    input wire logic [ISSUE_WIDTH-1:0] brIsAx,
    input wire logic [ISSUE_WIDTH-1:0] brTaken,
    input wire logic [ISSUE_WIDTH-1:0] brIsCond,
    input wire pcT [ISSUE_WIDTH-1:0] brAddr,
    input wire pcT [ISSUE_WIDTH-1:0] brTarget,
    output logic ready,
    output logic [FETCH_WIDTH-1:0] hit,
    output logic [FETCH_WIDTH-1:0] isCondBr,
    output pcT [FETCH_WIDTH-1:0] target
);

    typedef enum logic {
        ST_CLEAR,
        ST_READY
    } btbStateT;

    btbStateT state;
    btbIndexT initIndex;

    // Entry array ports.
    logic [ISSUE_WIDTH-1:0] we;
    btbIndexT [ISSUE_WIDTH-1:0] wa;
    btbEntryT [ISSUE_WIDTH-1:0] wv;
    btbIndexT [FETCH_WIDTH-1:0] ra;
    btbEntryT [FETCH_WIDTH-1:0] rv;

    // Slot addresses this cycle and the ones sampled at the last edge.
    pcT [FETCH_WIDTH-1:0] slotPc;
    pcT [FETCH_WIDTH-1:0] tagReg;

    logic [ISSUE_WIDTH-1:0] qualify;
    logic directWrite;
    logic pushQueue;
    logic popQueue;
    logic full;
    logic empty;
    qPtrT headPtr;
    qPtrT tailPtr;
    btbIndexT pushIndex;
    btbEntryT pushEntry;

    // Queue payload, indexed by the pointer block.
    btbIndexT queueIndex [QUEUE_SIZE];
    btbEntryT queueEntry [QUEUE_SIZE];

    btbEntryRam #(
        .ENTRY_NUM(ENTRY_NUM),
        .READ_NUM(FETCH_WIDTH),
        .WRITE_NUM(ISSUE_WIDTH)
    ) uEntryRam (
        .clk(clk),
        .we(we),
        .wa(wa),
        .wv(wv),
        .ra(ra),
        .rv(rv)
    );

    updateQueuePtr #(
        .QUEUE_SIZE(QUEUE_SIZE)
    ) uQueuePtr (
        .clk(clk),
        .rstN(rstN),
        .push(pushQueue),
        .pop(popQueue),
        .full(full),
        .empty(empty),
        .headPtr(headPtr),
        .tailPtr(tailPtr)
    );

    // Clear walk: one entry per cycle, then ready for good.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= ST_CLEAR;
            initIndex <= '0;
        end else if (state == ST_CLEAR) begin
            initIndex <= initIndex + 1'b1;
            if (initIndex == btbIndexT'(ENTRY_NUM - 1)) begin
                state <= ST_READY;
            end
        end
    end

    assign ready = (state == ST_READY);

    // Lookup addresses for every fetch slot.
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            slotPc[i] = predNextPc + pcT'(i * INSN_BYTES);
            ra[i] = toBtbIndex(slotPc[i]);
        end
    end

    always_ff @(posedge clk) begin
        tagReg <= slotPc;
    end

    // Compare against the slot address the RAM output belongs to.
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            hit[i] = ready && rv[i].valid && (rv[i].tag == toBtbTag(tagReg[i]));
            isCondBr[i] = hit[i] && rv[i].isCondBr;
            target[i] = toTarget(tagReg[i], rv[i].addr);
        end
    end

    assign qualify = brValid & brIsAx & brTaken;

    // Lowest qualifying lane goes straight in, the rest overflow.
    always_comb begin
        directWrite = 1'b0;
        pushQueue = 1'b0;
        popQueue = 1'b0;
        pushIndex = '0;
        pushEntry = '0;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            we[i] = 1'b0;
            wa[i] = toBtbIndex(brAddr[i]);
            wv[i].valid = 1'b1;
            wv[i].isCondBr = brIsCond[i];
            wv[i].tag = toBtbTag(brAddr[i]);
            wv[i].addr = toBtbAddr(brTarget[i]);
        end
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (qualify[i]) begin
                if (directWrite) begin
                    // Highest extra lane ends up in the queue.
                    pushQueue = 1'b1;
                    pushIndex = wa[i];
                    pushEntry = wv[i];
                end else begin
                    we[i] = 1'b1;
                    directWrite = 1'b1;
                end
            end
        end

        // Drain through port 0 when no lane wrote directly.
        if (!empty && !directWrite) begin
            popQueue = 1'b1;
            we[0] = 1'b1;
            wa[0] = queueIndex[tailPtr];
            wv[0] = queueEntry[tailPtr];
        end

        // While clearing, only port 0 runs and it invalidates entries.
        if (state == ST_CLEAR) begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                we[i] = (i == 0);
                wa[i] = initIndex;
                wv[i] = '0;
            end
            pushQueue = 1'b0;
            popQueue = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pushQueue && !full) begin
            queueIndex[headPtr] <= pushIndex;
            queueEntry[headPtr] <= pushEntry;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) ready |=> ready)
        else $error("branchTargetBuffer: ready dropped after clear");

endmodule

`default_nettype wire

// ==== design/btbTop.sv ====
// ======================================================================
// BTB top level.
// Fixes the buffer geometry and wires it to the fetch and issue ports.
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module btbTop import btbPkg::*; #(
    parameter int FETCH_WIDTH = 2,
    parameter int ISSUE_WIDTH = 2,
    parameter int ENTRY_NUM = 64,
    parameter int QUEUE_SIZE = 4
) (
    input wire logic clk,
    input wire logic rstN,
    input wire pcT predNextPc,
    input wire logic [ISSUE_WIDTH-1:0] brValid,
    input wire logic [ISSUE_WIDTH-1:0] brIsAx,
    input wire logic [ISSUE_WIDTH-1:0] brTaken,
    input wire logic [ISSUE_WIDTH-1:0] brIsCond,
    input wire pcT [ISSUE_WIDTH-1:0] brAddr,
    input wire pcT [ISSUE_WIDTH-1:0] brTarget,
    output logic ready,
    output logic [FETCH_WIDTH-1:0] hit,
    output logic [FETCH_WIDTH-1:0] isCondBr,
    output pcT [FETCH_WIDTH-1:0] target
);

    branchTargetBuffer #(
        .FETCH_WIDTH(FETCH_WIDTH),
        .ISSUE_WIDTH(ISSUE_WIDTH),
        .ENTRY_NUM(ENTRY_NUM),
        .QUEUE_SIZE(QUEUE_SIZE)
    ) uBtb (
        .clk(clk),
        .rstN(rstN),
        .predNextPc(predNextPc),
        .brValid(brValid),
        .brIsAx(brIsAx),
        .brTaken(brTaken),
        .brIsCond(brIsCond),
        .brAddr(brAddr),
        .brTarget(brTarget),
        .ready(ready),
        .hit(hit),
        .isCondBr(isCondBr),
        .target(target)
    );

endmodule

`default_nettype wire

// ==== tb/tbClockGen.sv ====
// ======================================================================
// Testbench clock and reset source.
// 20 ns clock with an active-low reset held for the first 16 cycles.
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module tbClockGen #(
    parameter int HALF_PERIOD = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Released on a rising edge, so the next edge is the first active one.
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb/btbTb.sv ====
// ======================================================================
// BTB testbench.
// Replays the stimulus file cycle by cycle and checks every lookup
// result one cycle after its fetch PC was driven.
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module btbTb import btbPkg::*; ();

    localparam int FETCH_WIDTH = 2;
    localparam int ISSUE_WIDTH = 2;
    localparam int ENTRY_NUM = 64;
    localparam int QUEUE_SIZE = 4;
    localparam string STIM_FILE = "tb/btbStimulus.txt";

    // One stimulus line. Lane flags are {valid, isAx, taken, isCond}.
    typedef struct packed {
        pcT fetchPc;
        logic [ISSUE_WIDTH-1:0][3:0] laneFlags;
        pcT [ISSUE_WIDTH-1:0] laneAddr;
        pcT [ISSUE_WIDTH-1:0] laneTarget;
        logic doCheck;
        logic [FETCH_WIDTH-1:0] expHit;
        logic [FETCH_WIDTH-1:0] expCond;
        pcT [FETCH_WIDTH-1:0] expTarget;
    } stimLineT;

    logic clk;
    logic rstN;
    pcT predNextPc;
    logic [ISSUE_WIDTH-1:0] brValid;
    logic [ISSUE_WIDTH-1:0] brIsAx;
    logic [ISSUE_WIDTH-1:0] brTaken;
    logic [ISSUE_WIDTH-1:0] brIsCond;
    pcT [ISSUE_WIDTH-1:0] brAddr;
    pcT [ISSUE_WIDTH-1:0] brTarget;
    logic ready;
    logic [FETCH_WIDTH-1:0] hit;
    logic [FETCH_WIDTH-1:0] isCondBr;
    pcT [FETCH_WIDTH-1:0] target;

    stimLineT stimLines[$];
    int cycleCount = 0;
    int cycleLimit = 0;

    tbClockGen uClockGen (
        .clk(clk),
        .rstN(rstN)
    );

    btbTop #(
        .FETCH_WIDTH(FETCH_WIDTH),
        .ISSUE_WIDTH(ISSUE_WIDTH),
        .ENTRY_NUM(ENTRY_NUM),
        .QUEUE_SIZE(QUEUE_SIZE)
    ) DUT (
        .clk(clk),
        .rstN(rstN),
        .predNextPc(predNextPc),
        .brValid(brValid),
        .brIsAx(brIsAx),
        .brTaken(brTaken),
        .brIsCond(brIsCond),
        .brAddr(brAddr),
        .brTarget(brTarget),
        .ready(ready),
        .hit(hit),
        .isCondBr(isCondBr),
        .target(target)
    );

    task automatic stopOnError(string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic checkHit(string name, logic got, logic exp);
        if (got !== exp) begin
            stopOnError($sformatf("CHECK FAILED: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkTarget(string name, pcT got, pcT exp);
        if (got !== exp) begin
            stopOnError($sformatf("CHECK FAILED: %s got %h expected %h", name, got, exp));
        end
    endtask

    // Fixed two-lane, two-slot column layout.
    task automatic readStimulus();
        int fd;
        int fields;
        string line;
        stimLineT s;
        pcT pc;
        pcT a0;
        pcT t0;
        pcT a1;
        pcT t1;
        pcT g0;
        pcT g1;
        logic [3:0] f0;
        logic [3:0] f1;
        logic chk;
        logic [1:0] e0;
        logic [1:0] e1;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            stopOnError("Could not open the stimulus file.");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Header and blank lines scan no fields.
            fields = $sscanf(line, "%h %b %h %h %b %h %h %b %b %h %b %h",
                             pc, f0, a0, t0, f1, a1, t1, chk, e0, g0, e1, g1);
            if (fields == 12) begin
                s.fetchPc = pc;
                s.laneFlags = {f1, f0};
                s.laneAddr = {a1, a0};
                s.laneTarget = {t1, t0};
                s.doCheck = chk;
                s.expHit = {e1[1], e0[1]};
                s.expCond = {e1[0], e0[0]};
                s.expTarget = {g1, g0};
                stimLines.push_back(s);
            end else if (fields > 0) begin
                stopOnError($sformatf("Stimulus line %0d is malformed.", stimLines.size()));
            end
        end
        $fclose(fd);
    endtask

    task automatic clearInputs();
        predNextPc <= '0;
        brValid <= '0;
        brIsAx <= '0;
        brTaken <= '0;
        brIsCond <= '0;
        brAddr <= '0;
        brTarget <= '0;
    endtask

    // Idle lanes get random filler so their payload cannot matter.
    task automatic driveLine(stimLineT s);
        logic [31:0] rnd;
        predNextPc <= s.fetchPc;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            brValid[i] <= s.laneFlags[i][3];
            brIsAx[i] <= s.laneFlags[i][2];
            brTaken[i] <= s.laneFlags[i][1];
            if (s.laneFlags[i] == 4'b0000) begin
                rnd = $urandom;
                brIsCond[i] <= rnd[0];
                brAddr[i] <= pcT'($urandom);
                brTarget[i] <= pcT'($urandom);
            end else begin
                brIsCond[i] <= s.laneFlags[i][0];
                brAddr[i] <= s.laneAddr[i];
                brTarget[i] <= s.laneTarget[i];
            end
        end
    endtask

    // Target is only meaningful on a hit.
    task automatic checkLine(stimLineT s, int lineNo);
        checkHit($sformatf("ready line %0d", lineNo), ready, 1'b1);
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            checkHit($sformatf("hit[%0d] line %0d", i, lineNo), hit[i], s.expHit[i]);
            checkHit($sformatf("isCondBr[%0d] line %0d", i, lineNo), isCondBr[i], s.expCond[i]);
            if (s.expHit[i]) begin
                checkTarget($sformatf("target[%0d] line %0d", i, lineNo),
                            target[i], s.expTarget[i]);
            end
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            stopOnError($sformatf("Timeout: the run went past %0d cycles.", cycleLimit));
        end
    end

    initial begin
        int readyDelay;
        void'($urandom(32'h83d0));
        clearInputs();
        readStimulus();
        cycleLimit = stimLines.size() + ENTRY_NUM + 100;

        // Clear walk: count cycles until ready, no hits meanwhile.
        wait (rstN === 1'b1);
        readyDelay = 0;
        @(negedge clk);
        while (ready !== 1'b1) begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                checkHit($sformatf("hit[%0d] during clear", i), hit[i], 1'b0);
            end
            readyDelay++;
            @(negedge clk);
        end
        if (readyDelay != ENTRY_NUM) begin
            stopOnError($sformatf("CHECK FAILED: ready delay got %h expected %h",
                                  readyDelay, ENTRY_NUM));
        end

        // Line k is driven at edge k and checked after edge k+1.
        for (int k = 0; k <= stimLines.size(); k++) begin
            @(posedge clk);
            if (k < stimLines.size()) begin
                driveLine(stimLines[k]);
            end else begin
                clearInputs();
            end
            @(negedge clk);
            if (k > 0 && stimLines[k-1].doCheck) begin
                checkLine(stimLines[k-1], k - 1);
            end
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/btbStimulus.txt ====
# pc | lane0: vatc addr target | lane1: vatc addr target | chk | slot0: hc target | slot1: hc target
# vatc = valid isAx taken isCond; hc = expected hit and isCondBr; idle lanes use 0000
00001000 0000 00000000 00000000 0000 00000000 00000000 1 00 00000000 00 00000000
00002000 0000 00000000 00000000 0000 00000000 00000000 1 00 00000000 00 00000000
00003000 1111 00001000 00052468 0000 00000000 00000000 0 00 00000000 00 00000000
00001000 0000 00000000 00000000 0000 00000000 00000000 1 11 00002468 00 00000000
00004000 0111 00001108 00001200 1011 00001210 00001300 0 00 00000000 00 00000000
00005000 1101 00001318 00001400 0000 00000000 00000000 0 00 00000000 00 00000000
00001108 0000 00000000 00000000 0000 00000000 00000000 1 00 00000000 00 00000000
00001210 0000 00000000 00000000 0000 00000000 00000000 1 00 00000000 00 00000000
00001318 0000 00000000 00000000 0000 00000000 00000000 1 00 00000000 00 00000000
00001000 0000 00000000 00000000 0000 00000000 00000000 1 11 00002468 00 00000000
00006000 1110 00002020 0007a5a4 1111 00002424 00003330 0 00 00000000 00 00000000
00007000 0000 00000000 00000000 0000 00000000 00000000 0 00 00000000 00 00000000
00002020 0000 00000000 00000000 0000 00000000 00000000 1 10 0000a5a4 00 00000000
00002424 0000 00000000 00000000 0000 00000000 00000000 1 11 00003330 00 00000000
00008000 1111 00003040 00003100 1110 00003144 00045678 0 00 00000000 00 00000000
00009000 0000 00000000 00000000 1111 00003248 00003500 0 00 00000000 00 00000000
0000a000 0000 00000000 00000000 0000 00000000 00000000 0 00 00000000 00 00000000
00003040 0000 00000000 00000000 0000 00000000 00000000 1 11 00003100 00 00000000
00003144 0000 00000000 00000000 0000 00000000 00000000 1 10 00005678 00 00000000
00003244 0000 00000000 00000000 0000 00000000 00000000 1 00 00000000 11 00003500
00004400 0000 00000000 00000000 0000 00000000 00000000 1 00 00000000 00 00000000
0000b000 1110 00004400 00006664 0000 00000000 00000000 0 00 00000000 00 00000000
00001000 0000 00000000 00000000 0000 00000000 00000000 1 00 00000000 00 00000000
00004400 0000 00000000 00000000 0000 00000000 00000000 1 10 00006664 00 00000000
0000c000 0000 00000000 00000000 1111 00020000 00001238 0 00 00000000 00 00000000
0001fffc 0000 00000000 00000000 0000 00000000 00000000 1 00 00000000 11 00021238
00020000 0000 00000000 00000000 0000 00000000 00000000 1 11 00021238 00 00000000
00060000 0000 00000000 00000000 0000 00000000 00000000 1 11 00061238 00 00000000

// ==== compile.f ====
design/btbPkg.sv
design/btbEntryRam.sv
design/updateQueuePtr.sv
design/branchTargetBuffer.sv
design/btbTop.sv
tb/tbClockGen.sv
tb/btbTb.sv

// ==== Makefile ====
# Verilator build and run for the BTB testbench.

VERILATOR ?= verilator
TOP ?= btbTb
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= ALL CHECKS PASSED

SOURCES := $(wildcard design/*.sv tb/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
